// ==== verilog/cpu_pkg.sv ====
/*
 * Shared types for the 16-bit microcoded core: instruction fields,
 * ALU functions, flags, micro-control word and sequencer states
 */
package cpu_pkg;

    // data word and 23-bit word address (byte address bits 23:1)
    typedef logic [15:0] word_t;
    typedef logic [22:0] waddr_t;

    // one of r0..r3
    typedef logic [1:0] rsel_t;

    // opcode lives in ir[15:12]
    typedef enum logic [3:0] {
        op_ldi  = 4'd0,
        op_add  = 4'd1,
        op_sub  = 4'd2,
        op_and  = 4'd3,
        op_or   = 4'd4,
        op_xor  = 4'd5,
        op_ld   = 4'd6,
        op_st   = 4'd7,
        op_jp   = 4'd8,
        op_jz   = 4'd9,
        op_halt = 4'd10
    } opcode_t;

    typedef enum logic [2:0] {
        alu_pass,
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor
    } alu_op_t;

    // ir[11:10] rd, ir[9:8] rs, ir[7:0] imm8
    typedef struct packed {
        opcode_t    opcode;
        rsel_t      rd;
        rsel_t      rs;
        logic [7:0] imm8;
    } instr_t;

    typedef struct packed {
        logic z;
        logic c;
        logic n;
    } flags_t;

    // register write source
    localparam logic [1:0] ld_alu = 2'd0;
    localparam logic [1:0] ld_mem = 2'd1;
    localparam logic [1:0] ld_imm = 2'd2;

    // effective address source
    localparam logic ea_pc = 1'b0;
    localparam logic ea_rs = 1'b1;

    // micro-control word, one per cycle
    typedef struct packed {
        alu_op_t    alu_op;
        logic       rd_we;
        logic [1:0] ld_sel;
        logic       flags_we;
        logic       ir_we;
        logic       pc_inc;
        logic       pc_load;
        logic       mem_req;
        logic       mem_wr;
        logic       ea_sel;
    } ctrl_t;

    typedef enum logic [2:0] {
        st_fetch,
        st_decode,
        st_exec,
        st_mem_wait,
        st_halted
    } seq_state_t;

endpackage

// ==== verilog/cpu_ctrl.sv ====
/*
 * Control sequencer: steps fetch, decode, exec and memory wait,
 * decoding the instruction register into micro-control
 */
module cpu_ctrl import cpu_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   cen,
    input  instr_t ir,
    input  flags_t flags,
    input  logic   mem_busy,
    output ctrl_t  uc
);

    seq_state_t state;
    seq_state_t state_nxt;
    alu_op_t    alu_fn;
    logic       is_st;

    assign is_st = ir.opcode == op_st;

    // opcode to ALU function
    always_comb begin
        case (ir.opcode)
            op_add:  alu_fn = alu_add;
            op_sub:  alu_fn = alu_sub;
            op_and:  alu_fn = alu_and;
            op_or:   alu_fn = alu_or;
            op_xor:  alu_fn = alu_xor;
            default: alu_fn = alu_pass;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= st_fetch;
        end else if (cen) begin
            state <= state_nxt;
        end
    end

    always_comb begin
        uc        = '0;
        uc.alu_op = alu_pass;
        uc.ld_sel = ld_alu;
        uc.ea_sel = ea_pc;
        state_nxt = state;
        case (state)
            st_fetch: begin
                // word at pc, possibly already launched by the last exec
                uc.mem_req = 1'b1;
                if (!mem_busy) begin
                    uc.ir_we  = 1'b1;
                    uc.pc_inc = 1'b1;
                    state_nxt = st_decode;
                end
            end
            st_decode: begin
                state_nxt = st_exec;
            end
            st_exec: begin
                state_nxt = st_fetch;
                case (ir.opcode)
                    op_ldi: begin
                        uc.rd_we   = 1'b1;
                        uc.ld_sel  = ld_imm;
                        // prefetch next word while pc is settled
                        uc.mem_req = 1'b1;
                    end
                    op_add, op_sub, op_and, op_or, op_xor: begin
                        uc.alu_op   = alu_fn;
                        uc.rd_we    = 1'b1;
                        uc.flags_we = 1'b1;
                        uc.mem_req  = 1'b1;
                    end
                    op_ld, op_st: begin
                        // pointer is rs
                        uc.mem_req = 1'b1;
                        uc.mem_wr  = is_st;
                        uc.ea_sel  = ea_rs;
                        state_nxt  = st_mem_wait;
                    end
                    // jumps fetch from the new pc, no prefetch
                    op_jp:   uc.pc_load = 1'b1;
                    op_jz:   uc.pc_load = flags.z;
                    // halt and unused opcodes stop the core
                    default: state_nxt = st_halted;
                endcase
            end
            st_mem_wait: begin
                uc.mem_req = 1'b1;
                uc.mem_wr  = is_st;
                uc.ea_sel  = ea_rs;
                if (!mem_busy) begin
                    uc.rd_we  = ~is_st;
                    uc.ld_sel = ld_mem;
                    state_nxt = st_fetch;
                end
            end
            default: begin
                // halted, no further bus cycles
                state_nxt = st_halted;
            end
        endcase
    end

endmodule

// ==== verilog/cpu_regs.sv ====
/*
 * Register unit: r0..r3, program counter, instruction register and flags
 */
module cpu_regs import cpu_pkg::*; #(
    parameter waddr_t RESET_PC = '0
) (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   cen,
    input  ctrl_t  uc,
    input  word_t  mdata,
    input  word_t  rslt,
    input  flags_t flags_out,
    output instr_t ir,
    output flags_t flags,
    output waddr_t pc,
    output word_t  op_a,
    output word_t  op_b
);

    word_t  gpr [4];
    word_t  wr_data;
    waddr_t jmp_addr;

    // operand reads straight from the ir fields
    assign op_a = gpr[ir.rd];
    assign op_b = gpr[ir.rs];

    // jump target, imm8 zero extended
    assign jmp_addr = waddr_t'(ir.imm8);

    always_comb begin
        case (uc.ld_sel)
            ld_mem:  wr_data = mdata;
            ld_imm:  wr_data = {8'h00, ir.imm8};
            default: wr_data = rslt;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 4; i++) begin
                gpr[i] <= '0;
            end
            pc    <= RESET_PC;
            ir    <= '0;
            flags <= '0;
        end else if (cen) begin
            if (uc.rd_we) begin
                gpr[ir.rd] <= wr_data;
            end
            if (uc.flags_we) begin
                flags <= flags_out;
            end
            if (uc.ir_we) begin
                ir <= instr_t'(mdata);
            end
            // taken jump wins over increment
            if (uc.pc_load) begin
                pc <= jmp_addr;
            end else if (uc.pc_inc) begin
                pc <= pc + 23'd1;
            end
        end
    end

endmodule

// ==== verilog/cpu_alu.sv ====
/*
 * Combinational 16-bit ALU with zero, carry and negative flags
 */
module cpu_alu import cpu_pkg::*; (
    input  ctrl_t  uc,
    input  word_t  op_a,
    input  word_t  op_b,
    input  flags_t flags_in,
    output word_t  rslt,
    output flags_t flags_out
);

    // bit 16 is carry out or borrow
    logic [16:0] wide;
    logic        carry;

    always_comb begin
        wide  = '0;
        // logic ops keep the old carry
        carry = flags_in.c;
        case (uc.alu_op)
            alu_add: begin
                wide  = {1'b0, op_a} + {1'b0, op_b};
                carry = wide[16];
            end
            alu_sub: begin
                // wraps to bit 16 when op_b > op_a
                wide  = {1'b0, op_a} - {1'b0, op_b};
                carry = wide[16];
            end
            alu_and: wide = {1'b0, op_a & op_b};
            alu_or:  wide = {1'b0, op_a | op_b};
            alu_xor: wide = {1'b0, op_a ^ op_b};
            // pass forwards rs
            default: wide = {1'b0, op_b};
        endcase
    end

    assign rslt = wide[15:0];

    always_comb begin
        flags_out.z = rslt == '0;
        flags_out.c = carry;
        flags_out.n = rslt[15];
    end

endmodule

// ==== verilog/cpu_mem.sv ====
/*
 * Memory unit: runs fetch, load and store cycles on the word bus,
 * holding each request until busy drops
 */
module cpu_mem import cpu_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       cen,
    input  ctrl_t      uc,
    input  waddr_t     pc,
    input  word_t      op_a,
    input  word_t      op_b,
    output word_t      mdata,
    output logic       mem_busy,
    output waddr_t     addr,
    input  word_t      din,
    output word_t      dout,
    output logic [1:0] we,
    output logic       rd,
    input  logic       busy
);

    logic active;

    // a bus cycle is open while rd or we is up
    assign active = rd || we != 2'b00;

    // done on the first enabled cycle with busy low
    assign mem_busy = !(active && !busy);

    // read data passes straight through, captured by the register unit
    assign mdata = din;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            addr <= '0;
            dout <= '0;
            we   <= 2'b00;
            rd   <= 1'b0;
        end else if (cen) begin
            if (active) begin
                // hold while busy, drop on completion
                if (!busy) begin
                    we <= 2'b00;
                    rd <= 1'b0;
                end
            end else if (uc.mem_req) begin
                // pointer from rs, zero extended
                addr <= (uc.ea_sel == ea_rs) ? waddr_t'(op_b) : pc;
                // store data comes from rd
                dout <= op_a;
                we   <= {2{uc.mem_wr}};
                rd   <= ~uc.mem_wr;
            end
        end
    end

endmodule

// ==== verilog/cpu_top.sv ====
/*
 * 16-bit core top level: sequencer, register unit, ALU and memory unit
 * wired to the external word bus
 */
module cpu_top import cpu_pkg::*; #(
    parameter waddr_t RESET_PC = '0
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       cen,
    output waddr_t     addr,
    input  word_t      din,
    output word_t      dout,
    output logic [1:0] we,
    output logic       rd,
    input  logic       busy
);

    // micro-control from the sequencer
    ctrl_t  uc;

    // register unit outputs
    instr_t ir;
    flags_t flags;
    waddr_t pc;
    word_t  op_a;
    word_t  op_b;

    // ALU results
    word_t  rslt;
    flags_t flags_out;

    // memory unit back to the core
    word_t  mdata;
    logic   mem_busy;

    cpu_ctrl u_ctrl (
        .clk      (clk),
        .rst_n    (rst_n),
        .cen      (cen),
        .ir       (ir),
        .flags    (flags),
        .mem_busy (mem_busy),
        .uc       (uc)
    );

    cpu_regs #(
        .RESET_PC (RESET_PC)
    ) u_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .cen       (cen),
        .uc        (uc),
        .mdata     (mdata),
        .rslt      (rslt),
        .flags_out (flags_out),
        .ir        (ir),
        .flags     (flags),
        .pc        (pc),
        .op_a      (op_a),
        .op_b      (op_b)
    );

    cpu_alu u_alu (
        .uc        (uc),
        .op_a      (op_a),
        .op_b      (op_b),
        .flags_in  (flags),
        .rslt      (rslt),
        .flags_out (flags_out)
    );

    cpu_mem u_mem (
        .clk      (clk),
        .rst_n    (rst_n),
        .cen      (cen),
        .uc       (uc),
        .pc       (pc),
        .op_a     (op_a),
        .op_b     (op_b),
        .mdata    (mdata),
        .mem_busy (mem_busy),
        .addr     (addr),
        .din      (din),
        .dout     (dout),
        .we       (we),
        .rd       (rd),
        .busy     (busy)
    );

endmodule

// ==== bench/cpu_props.sv ====
/*
 * Bus protocol assertions for the 16-bit core, bound to cpu_top
 */
module cpu_props import cpu_pkg::*; (
    input logic       clk,
    input logic       rst_n,
    input logic       busy,
    input logic       rd,
    input logic [1:0] we,
    input waddr_t     addr
);

    // count of failed assertions
    int unsigned fails = 0;

    // a transfer is either a read or a write
    rd_we_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(rd && we != 2'b00))
        else begin
            fails++;
            $error("rd and we active in the same cycle");
        end

    // request frozen while the memory stalls
    req_hold: assert property (@(posedge clk) disable iff (!rst_n)
        busy && (rd || we != 2'b00) |=> $stable(addr) && $stable(rd) && $stable(we))
        else begin
            fails++;
            $error("bus request changed while busy was high");
        end

    // reset leaves the bus idle
    rst_idle: assert property (@(posedge clk)
        !rst_n |=> !rd && we == 2'b00)
        else begin
            fails++;
            $error("bus not idle after reset");
        end

endmodule

bind cpu_top cpu_props u_props (
    .clk   (clk),
    .rst_n (rst_n),
    .busy  (busy),
    .rd    (rd),
    .we    (we),
    .addr  (addr)
);

// ==== bench/cpu_tb.sv ====
/*
 * Testbench for the 16-bit core: word bus memory with random wait states,
 * a small program assembler and directed tests
 */
module cpu_tb import cpu_pkg::*; ();

    // instructions over all programs, scales the watchdog
    localparam int test_len_sum = 10 + 22 + 10 + 17 + 22;
    localparam logic [7:0] alu_a = 8'h3C;
    localparam logic [7:0] alu_b = 8'hE5;

    logic       clk;
    logic       rst_n;
    logic       cen;
    waddr_t     addr;
    word_t      din;
    word_t      dout;
    logic [1:0] we;
    logic       rd;
    logic       busy;

    // memory model state
    word_t  mem [256];
    word_t  prog [$];
    logic   pending;
    int     wait_left;
    int     write_hits [256];
    int     write_count;
    logic   halt_seen;
    int     idle_cycles;
    logic   cen_toggle;
    int     errors;
    int     assert_fails;

    // bus as the DUT sees it at the coming edge
    logic       s_rst_n = 1'b0;
    logic       s_cen = 1'b0;
    logic       s_busy = 1'b0;
    logic       s_rd = 1'b0;
    logic [1:0] s_we = 2'b00;
    waddr_t     s_addr = '0;
    word_t      s_dout = '0;

    cpu_top #(
        .RESET_PC (23'd0)
    ) cpu_top_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .cen   (cen),
        .addr  (addr),
        .din   (din),
        .dout  (dout),
        .we    (we),
        .rd    (rd),
        .busy  (busy)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // mid-cycle, everything settled
    always @(negedge clk) begin
        s_rst_n = rst_n;
        s_cen   = cen;
        s_busy  = busy;
        s_rd    = rd;
        s_we    = we;
        s_addr  = addr;
        s_dout  = dout;
    end

    // finish the transfer the DUT just saw complete
    task automatic complete_transfer();
        if (s_we != 2'b00) begin
            if (s_we[0]) mem[s_addr[7:0]][7:0] = s_dout[7:0];
            if (s_we[1]) mem[s_addr[7:0]][15:8] = s_dout[15:8];
            write_hits[s_addr[7:0]]++;
            write_count++;
        end else if (mem[s_addr[7:0]][15:12] == op_halt) begin
            halt_seen = 1'b1;
        end
    endtask

    always @(posedge clk) begin
        #1;
        if (!s_rst_n) begin
            pending   = 1'b0;
            wait_left = 0;
        end else if (s_cen && pending) begin
            // busy low at an enabled edge ends the transfer
            if (!s_busy) begin
                complete_transfer();
                pending = 1'b0;
            end else begin
                wait_left--;
            end
        end
        // quiet enabled cycles after the halt word came in
        if (s_rst_n && s_cen && halt_seen) begin
            if (s_rd || s_we != 2'b00) idle_cycles = 0;
            else idle_cycles++;
        end
        // new request, 0 to 3 wait states
        if (!pending && (rd || we != 2'b00)) begin
            pending   = 1'b1;
            wait_left = $urandom % 4;
        end
        busy = pending && wait_left > 0;
        din  = mem[addr[7:0]];
        cen  = cen_toggle ? ($urandom % 3 != 0) : 1'b1;
    end

    function automatic word_t fill_word(logic [7:0] a);
        return {4'h3, a, 4'h5};
    endfunction

    // 16-bit results as the instruction set defines them
    function automatic word_t alu_expect(opcode_t op, word_t a, word_t b);
        case (op)
            op_add:  return a + b;
            op_sub:  return a - b;
            op_and:  return a & b;
            op_or:   return a | b;
            default: return a ^ b;
        endcase
    endfunction

    task automatic check_value(string name, word_t exp, word_t act);
        if (act !== exp) begin
            errors++;
            $display("Error at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic fill_memory();
        for (int i = 0; i < 256; i++) begin
            mem[i] = fill_word(8'(i));
        end
        prog.delete();
    endtask

    // opcode, rd, rs, imm8
    task automatic emit(opcode_t op, rsel_t rd_sel, rsel_t rs_sel, logic [7:0] imm);
        prog.push_back({op, rd_sel, rs_sel, imm});
    endtask

    // load, reset for 5 cycles, run to halt plus 20 quiet cycles
    task automatic run_program();
        @(posedge clk);
        #1;
        rst_n = 1'b0;
        for (int i = 0; i < prog.size(); i++) begin
            mem[i] = prog[i];
        end
        halt_seen   = 1'b0;
        idle_cycles = 0;
        write_count = 0;
        for (int i = 0; i < 256; i++) begin
            write_hits[i] = 0;
        end
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        while (!(halt_seen && idle_cycles >= 20)) @(posedge clk);
    endtask

    task automatic check_mem(logic [7:0] a, word_t exp);
        check_value($sformatf("mem[%02h]", a), exp, mem[a]);
    endtask

    task automatic ldi_store_test();
        logic [7:0] vals [3] = '{8'h5A, 8'hFF, 8'h00};
        fill_memory();
        for (int i = 0; i < 3; i++) begin
            emit(op_ldi, 1, 0, 8'(8'h80 + i));
            emit(op_ldi, 0, 0, vals[i]);
            emit(op_st, 0, 1, 8'h00);
        end
        emit(op_halt, 0, 0, 8'h00);
        run_program();
        for (int i = 0; i < 3; i++) begin
            check_mem(8'(8'h80 + i), {8'h00, vals[i]});
        end
    endtask

    // r0 = a op b for each op, stored at 0x90 upward
    task automatic alu_test();
        opcode_t ops [5] = '{op_add, op_sub, op_and, op_or, op_xor};
        fill_memory();
        emit(op_ldi, 3, 0, alu_b);
        for (int i = 0; i < 5; i++) begin
            emit(op_ldi, 0, 0, alu_a);
            emit(ops[i], 0, 3, 8'h00);
            emit(op_ldi, 1, 0, 8'(8'h90 + i));
            emit(op_st, 0, 1, 8'h00);
        end
        emit(op_halt, 0, 0, 8'h00);
        run_program();
        for (int i = 0; i < 5; i++) begin
            check_mem(8'(8'h90 + i), alu_expect(ops[i], {8'h00, alu_a}, {8'h00, alu_b}));
            check_value($sformatf("write_hits[%02h]", 8'h90 + i), 16'd1,
                16'(write_hits[8'h90 + i]));
        end
        check_value("write_count", 16'd5, 16'(write_count));
    endtask

    task automatic load_store_test();
        word_t val_a = 16'h1234;
        word_t val_b = 16'h0F0F;
        fill_memory();
        mem[8'hA0] = val_a;
        mem[8'hA1] = val_b;
        emit(op_ldi, 1, 0, 8'hA0);
        emit(op_ld, 0, 1, 8'h00);
        emit(op_ldi, 2, 0, 8'hA1);
        emit(op_ld, 3, 2, 8'h00);
        emit(op_add, 0, 3, 8'h00);
        emit(op_ldi, 1, 0, 8'hB0);
        emit(op_st, 0, 1, 8'h00);
        emit(op_ldi, 2, 0, 8'hB1);
        emit(op_st, 3, 2, 8'h00);
        emit(op_halt, 0, 0, 8'h00);
        run_program();
        check_mem(8'hB0, val_a + val_b);
        check_mem(8'hB1, val_b);
    endtask

    // taken jz, untaken jz, jp over a store
    task automatic branch_test();
        fill_memory();
        emit(op_ldi, 0, 0, 8'h11);
        emit(op_ldi, 1, 0, 8'h11);
        emit(op_ldi, 2, 0, 8'hC0);
        emit(op_sub, 0, 1, 8'h00);
        emit(op_jz, 0, 0, 8'd6);
        emit(op_st, 1, 2, 8'h00);
        emit(op_ldi, 0, 0, 8'h22);
        emit(op_sub, 0, 1, 8'h00);
        emit(op_ldi, 2, 0, 8'hC1);
        emit(op_jz, 0, 0, 8'd11);
        emit(op_st, 1, 2, 8'h00);
        emit(op_jp, 0, 0, 8'd14);
        emit(op_ldi, 2, 0, 8'hC2);
        emit(op_st, 1, 2, 8'h00);
        emit(op_ldi, 2, 0, 8'hC3);
        emit(op_st, 0, 2, 8'h00);
        emit(op_halt, 0, 0, 8'h00);
        run_program();
        check_mem(8'hC0, fill_word(8'hC0));
        check_mem(8'hC1, 16'h0011);
        check_mem(8'hC2, fill_word(8'hC2));
        check_mem(8'hC3, 16'h0022 - 16'h0011);
    endtask

    // watchdog, 40 cycles per instruction over all tests
    initial begin
        repeat (test_len_sum * 40) @(posedge clk);
        $display("Timeout: the core did not finish its programs within %0d cycles",
            test_len_sum * 40);
        $display("Test failures found");
        $finish;
    end

    initial begin
        void'($urandom(32'h653e3796));
        errors       = 0;
        assert_fails = 0;
        rst_n        = 1'b0;
        cen          = 1'b1;
        din          = '0;
        busy         = 1'b0;
        cen_toggle   = 1'b0;
        pending      = 1'b0;
        wait_left    = 0;
        halt_seen    = 1'b0;
        idle_cycles  = 0;
        write_count  = 0;
        ldi_store_test();
        alu_test();
        load_store_test();
        branch_test();
        // same ALU program, now with cen dropping at random
        cen_toggle = 1'b1;
        alu_test();
        cen_toggle = 1'b0;
        assert_fails = cpu_top_inst.u_props.fails;
        $display("check errors: %0d, assertion failures: %0d", errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
verilog/cpu_pkg.sv
verilog/cpu_ctrl.sv
verilog/cpu_regs.sv
verilog/cpu_alu.sv
verilog/cpu_mem.sv
verilog/cpu_top.sv
bench/cpu_props.sv
bench/cpu_tb.sv

// ==== Bender.yml ====
package:
  name: cpu16

sources:
  - files:
      - verilog/cpu_pkg.sv
      - verilog/cpu_ctrl.sv
      - verilog/cpu_regs.sv
      - verilog/cpu_alu.sv
      - verilog/cpu_mem.sv
      - verilog/cpu_top.sv
  - target: test
    files:
      - bench/cpu_props.sv
      - bench/cpu_tb.sv
